/* tb.f */
+incdir+logic
logic/dcacheAddrPkg.sv
logic/dcacheCmdPkg.sv
logic/dcacheValid.sv
logic/dcacheWayStore.sv
logic/dcacheReqDecode.sv
logic/dcacheLookup.sv
logic/dcacheRespond.sv
logic/dcacheTop.sv
tb/dcacheTb.sv

/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := dcacheTb
FILELIST  := tb.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := *** PASSED ***

# Sources named in the file list, so a change triggers a rebuild
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SRCS) logic/dcache_defines.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The log decides the result, the simulator exit code is not trusted
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb/dcacheTb.sv */
// Data cache lookup engine testbench
`timescale 1ns/100ps

module dcacheTb import dcacheAddrPkg::*, dcacheCmdPkg::*; ();

	// Clock period in ns and input skew after the rising edge
	localparam int clkPeriod = 40;
	localparam int driveDelay = 2;

	// One stimulus row and the response that the cache rules predict for it
	typedef struct packed {
		dcOp op;
		logic [31:0] addr;
		dcLine line;
		logic hit;
		dcWay way;
		logic [31:0] data;
		logic err;
		logic noGap;
	} tableRow;

	// Response still owed by the DUT, with the cycle of its request
	typedef struct packed {
		dcResp exp;
		int issue;
		int row;
	} pendingEntry;

	logic clk = 1'b0;
	logic rst;
	logic reqValid;
	dcReq req;
	logic respValid;
	dcResp resp;

	tableRow rows [$];
	pendingEntry expQ [$];
	int tableLen = 0;
	int cycleCount = 0;
	logic [7:0] lfsrState = 8'd62;

	// Failure counters by kind
	int valueErrors = 0;
	int unexpectedErrors = 0;
	int latencyErrors = 0;

	dcacheTop dut_i (.clk, .rst, .reqValid, .req, .respValid, .resp);

	always #(clkPeriod / 2) clk = ~clk;

	// Rising edges since time zero, used to measure latency
	always @(posedge clk) cycleCount <= cycleCount + 1;

	// ========================================================================
	// Helpers
	// ========================================================================

	// Eight bit Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsrNext(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// Idle cycles before a row, two LFSR bits so 0 to 3
	function automatic int drawGap();
		logic [1:0] bits;
		lfsrState = lfsrNext(lfsrState);
		bits[0] = lfsrState[0];
		lfsrState = lfsrNext(lfsrState);
		bits[1] = lfsrState[0];
		return int'(bits);
	endfunction

	// Word aligned address from its cache fields
	function automatic logic [31:0] addrOf(input dcTag tag, input dcIndex index,
		input dcWordSel word);
		return {tag, index, word, 2'b00};
	endfunction

	// Line whose word i holds base plus i
	function automatic dcLine makeLine(input logic [31:0] base);
		dcLine l;
		for (int i = 0; i < 4; i++) begin
			l[i] = base + 32'(i);
		end
		return l;
	endfunction

	task automatic addRow(input dcOp op, input logic [31:0] addr, input dcLine line,
		input logic hit, input dcWay way, input logic [31:0] data, input logic err,
		input logic noGap);
		tableRow r;
		r.op = op;
		r.addr = addr;
		r.line = line;
		r.hit = hit;
		r.way = way;
		r.data = data;
		r.err = err;
		r.noGap = noGap;
		rows.push_back(r);
	endtask

	task automatic compareField(input string name, input logic [31:0] expected,
		input logic [31:0] actual, input int row);
		assert (actual === expected) else begin
			$display("error %s row %0d: expected %h, got %h", name, row, expected, actual);
			valueErrors++;
		end
	endtask

	// ========================================================================
	// Stimulus table
	// ========================================================================

	task automatic buildTable();
		dcTag setTags [4];
		logic [31:0] setBases [4];
		setTags = '{24'hA1, 24'hA2, 24'hA3, 24'hA4};
		setBases = '{32'hA1A10000, 32'hA2A20000, 32'hA3A30000, 32'hA4A40000};
		// Empty cache, every read misses
		addRow(opRead, addrOf(24'hA1, 4'd5, 2'd0), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, 32'h00001230, '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, 32'hFFFFFFF0, '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		// Four tags fill set 5 in way order, one more tag goes to set 9
		for (int t = 0; t < 4; t++) begin
			addRow(opFill, addrOf(setTags[t], 4'd5, 2'd0), makeLine(setBases[t]),
				1'b0, dcWay'(t), 32'h0, 1'b0, 1'b0);
		end
		addRow(opFill, addrOf(24'hB1, 4'd9, 2'd0), makeLine(32'hB1B10000),
			1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		// Every word of every line in set 5
		for (int t = 0; t < 4; t++) begin
			for (int w = 0; w < 4; w++) begin
				addRow(opRead, addrOf(setTags[t], 4'd5, dcWordSel'(w)), '0, 1'b1,
					dcWay'(t), setBases[t] + 32'(w), 1'b0, 1'b0);
			end
		end
		addRow(opRead, addrOf(24'hB1, 4'd9, 2'd3), '0, 1'b1, 2'd0, 32'hB1B10003, 1'b0, 1'b0);
		// Full set, the victim counter evicts way 0 then way 1
		addRow(opFill, addrOf(24'hA5, 4'd5, 2'd0), makeLine(32'hA5A50000),
			1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opFill, addrOf(24'hA6, 4'd5, 2'd0), makeLine(32'hA6A60000),
			1'b0, 2'd1, 32'h0, 1'b0, 1'b0);
		// Refill of a resident tag keeps its way and leaves the counter alone
		addRow(opFill, addrOf(24'hA3, 4'd5, 2'd0), makeLine(32'h33330000),
			1'b1, 2'd2, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA1, 4'd5, 2'd0), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA2, 4'd5, 2'd1), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA5, 4'd5, 2'd1), '0, 1'b1, 2'd0, 32'hA5A50001, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA6, 4'd5, 2'd3), '0, 1'b1, 2'd1, 32'hA6A60003, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA3, 4'd5, 2'd2), '0, 1'b1, 2'd2, 32'h33330002, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA4, 4'd5, 2'd0), '0, 1'b1, 2'd3, 32'hA4A40000, 1'b0, 1'b0);
		// Clear set 5 only, set 9 keeps its line
		addRow(opInvLine, addrOf(24'h0, 4'd5, 2'd0), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA5, 4'd5, 2'd0), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA3, 4'd5, 2'd2), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA4, 4'd5, 2'd3), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hB1, 4'd9, 2'd1), '0, 1'b1, 2'd0, 32'hB1B10001, 1'b0, 1'b0);
		// Lowest invalid way wins over the victim counter
		addRow(opFill, addrOf(24'hA7, 4'd5, 2'd0), makeLine(32'hA7A70000),
			1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA7, 4'd5, 2'd2), '0, 1'b1, 2'd0, 32'hA7A70002, 1'b0, 1'b0);
		// Global clear, then back to back rows with no idle cycle
		addRow(opInvAll, 32'h0, '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hB1, 4'd9, 2'd0), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hA7, 4'd5, 2'd0), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opFill, addrOf(24'hC1, 4'd3, 2'd0), makeLine(32'hC1C10000),
			1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hC1, 4'd3, 2'd2), '0, 1'b1, 2'd0, 32'hC1C10002, 1'b0, 1'b1);
		addRow(opFill, addrOf(24'hC2, 4'd3, 2'd0), makeLine(32'hC2C20000),
			1'b0, 2'd1, 32'h0, 1'b0, 1'b1);
		addRow(opRead, addrOf(24'hC2, 4'd3, 2'd1), '0, 1'b1, 2'd1, 32'hC2C20001, 1'b0, 1'b1);
		addRow(opRead, addrOf(24'hC1, 4'd3, 2'd3), '0, 1'b1, 2'd0, 32'hC1C10003, 1'b0, 1'b1);
		addRow(opInvLine, addrOf(24'hC1, 4'd3, 2'd0), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b1);
		addRow(opRead, addrOf(24'hC2, 4'd3, 2'd0), '0, 1'b0, 2'd0, 32'h0, 1'b0, 1'b1);
		addRow(opFill, addrOf(24'hC3, 4'd3, 2'd0), makeLine(32'hC3C30000),
			1'b0, 2'd0, 32'h0, 1'b0, 1'b1);
		addRow(opRead, addrOf(24'hC3, 4'd3, 2'd0), '0, 1'b1, 2'd0, 32'hC3C30000, 1'b0, 1'b1);
		// Fill ignores its byte bits, a read with byte bits set is an error miss
		addRow(opFill, addrOf(24'hD1, 4'd12, 2'd1) | 32'h3, makeLine(32'hD1D10000),
			1'b0, 2'd0, 32'h0, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hD1, 4'd12, 2'd2) | 32'h1, '0, 1'b0, 2'd0, 32'h0, 1'b1, 1'b0);
		addRow(opRead, addrOf(24'hD1, 4'd12, 2'd1) | 32'h2, '0, 1'b0, 2'd0, 32'h0, 1'b1, 1'b1);
		addRow(opRead, addrOf(24'hD1, 4'd12, 2'd2), '0, 1'b1, 2'd0, 32'hD1D10002, 1'b0, 1'b0);
		addRow(opRead, addrOf(24'hE1, 4'd12, 2'd0) | 32'h3, '0, 1'b0, 2'd0, 32'h0, 1'b1, 1'b0);
	endtask

	// ========================================================================
	// Drive and check
	// ========================================================================

	initial begin
		int gap;
		pendingEntry p;
		rst = 1'b1;
		reqValid = 1'b0;
		req = '0;
		buildTable();
		tableLen = rows.size();
		repeat (8) @(posedge clk);
		#driveDelay;
		rst = 1'b0;
		// A quiet stretch in which respValid has to stay low
		repeat (4) begin
			@(posedge clk);
			#driveDelay;
		end
		for (int i = 0; i < rows.size(); i++) begin
			if (!rows[i].noGap) begin
				gap = drawGap();
				repeat (gap) begin
					@(posedge clk);
					#driveDelay;
				end
			end
			reqValid = 1'b1;
			req.op = rows[i].op;
			req.addr = rows[i].addr;
			req.line = rows[i].line;
			p.exp.op = rows[i].op;
			p.exp.hit = rows[i].hit;
			p.exp.way = rows[i].way;
			p.exp.data = rows[i].data;
			p.exp.err = rows[i].err;
			p.issue = cycleCount;
			p.row = i;
			expQ.push_back(p);
			@(posedge clk);
			#driveDelay;
			reqValid = 1'b0;
		end
		while (expQ.size() != 0) @(posedge clk);
		// A few more cycles to catch a stray response
		repeat (4) @(posedge clk);
		$display("errors: value %0d, unexpected %0d, latency %0d",
			valueErrors, unexpectedErrors, latencyErrors);
		if (valueErrors + unexpectedErrors + latencyErrors != 0) begin
			$display("*** FAILED ***");
		end else begin
			$display("*** PASSED ***");
		end
		$finish;
	end

	// Responses are sampled mid cycle, away from the clock edge
	always @(negedge clk) begin
		pendingEntry e;
		if (respValid !== 1'b0) begin
			assert (expQ.size() > 0) else begin
				$display("a response arrived with no request outstanding");
				unexpectedErrors++;
			end
			if (expQ.size() > 0) begin
				e = expQ.pop_front();
				assert (cycleCount - e.issue == 3) else begin
					$display("the response to row %0d came %0d cycles after its request",
						e.row, cycleCount - e.issue);
					latencyErrors++;
				end
				compareField("resp.op", 32'(e.exp.op), 32'(resp.op), e.row);
				compareField("resp.hit", 32'(e.exp.hit), 32'(resp.hit), e.row);
				compareField("resp.way", 32'(e.exp.way), 32'(resp.way), e.row);
				compareField("resp.data", e.exp.data, resp.data, e.row);
				compareField("resp.err", 32'(e.exp.err), 32'(resp.err), e.row);
			end
		end
	end

	// Eight cycles per row covers the worst gap and the latency
	initial begin
		wait (tableLen > 0);
		#((tableLen * 8 + 8) * clkPeriod);
		$display("the run took too long and responses are still missing");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* logic/dcacheTop.sv */
// Data cache lookup engine
`timescale 1ns/100ps

module dcacheTop import dcacheCmdPkg::*; (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input dcReq req,
	output logic respValid,
	output dcResp resp
);

	// Decode to lookup
	logic cmdValid;
	dcCmd cmd;

	// Lookup to respond
	logic resultValid;
	dcResp result;

	// Input side, one register
	dcacheReqDecode reqDecode (.clk, .rst, .reqValid, .req, .cmdValid, .cmd);

	// Stores, compare and writes, one register
	dcacheLookup lookup (.clk, .rst, .cmdValid, .cmd, .resultValid, .result);

	// Output side, one register
	dcacheRespond respond (.clk, .rst, .resultValid, .result, .respValid, .resp);

endmodule

/* logic/dcacheRespond.sv */
// Data cache response register
`timescale 1ns/100ps

module dcacheRespond import dcacheCmdPkg::*; (
	input logic clk,
	input logic rst,
	// Result from lookup
	input logic resultValid,
	input dcResp result,
	// Response at the cache boundary
	output logic respValid,
	output dcResp resp
);

	// ========================================================================
	// Output stage
	// ========================================================================

	// Strobe for the outside, one cycle per command
	always_ff @(posedge clk) begin
		if (rst) begin
			respValid <= 1'b0;
		end else begin
			respValid <= resultValid;
		end
	end

	// Payload follows the strobe
	// Data is only defined on a hit, so anything else goes out as zero
	always_ff @(posedge clk) begin
		if (resultValid) begin
			resp <= result;
			if (!result.hit) begin
				resp.data <= '0;
			end
		end
	end

endmodule

/* logic/dcacheLookup.sv */
// Data cache lookup
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcacheLookup import dcacheAddrPkg::*, dcacheCmdPkg::*; (
	input logic clk,
	input logic rst,
	// Decoded command from the input side
	input logic cmdValid,
	input dcCmd cmd,
	// Result towards the output register
	output logic resultValid,
	output dcResp result
);

	// Per-op strobes qualified by the command valid
	logic doRead;
	logic doFill;
	logic doInvLine;
	logic doInvAll;
	// Store outputs for the indexed set
	logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid;
	dcTag tagRd [`DC_WAYS];
	dcLine lineRd [`DC_WAYS];
	// Compare results
	logic [`DC_WAYS-1:0] setValid;
	logic [`DC_WAYS-1:0] wayHit;
	logic hitAny;
	dcWay hitWay;
	logic anyInvalid;
	dcWay firstInvalid;
	// Fill placement
	dcWay fillWay;
	dcWay victim;
	logic [31:0] hitWord;

	assign doRead = cmdValid && (cmd.op == opRead);
	assign doFill = cmdValid && (cmd.op == opFill);
	assign doInvLine = cmdValid && (cmd.op == opInvLine);
	assign doInvAll = cmdValid && (cmd.op == opInvAll);

	// ========================================================================
	// Stores
	// ========================================================================

	dcacheValid validStore (.clk, .rst, .fill(doFill), .fillWay, .index(cmd.addr.index),
		.invLine(doInvLine), .invAll(doInvAll), .valid);

	// Tags and line data share the same write and index
	dcacheWayStore #(.entryT(dcTag)) tagStore (.clk, .wr(doFill), .wrWay(fillWay),
		.index(cmd.addr.index), .wrData(cmd.addr.tag), .rdData(tagRd));

	dcacheWayStore #(.entryT(dcLine)) dataStore (.clk, .wr(doFill), .wrWay(fillWay),
		.index(cmd.addr.index), .wrData(cmd.line), .rdData(lineRd));

	// ========================================================================
	// Compare and way choice
	// ========================================================================

	always_comb begin
		hitWay = '0;
		firstInvalid = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			setValid[w] = valid[w][cmd.addr.index];
			wayHit[w] = setValid[w] && (tagRd[w] == cmd.addr.tag);
		end
		// Walk from the top way down so the lowest match wins
		for (int w = `DC_WAYS - 1; w >= 0; w--) begin
			if (wayHit[w]) hitWay = dcWay'(w);
			if (!setValid[w]) firstInvalid = dcWay'(w);
		end
	end

	assign hitAny = |wayHit;
	assign anyInvalid = ~&setValid;

	// Reuse a matching way, else take an empty one, else evict the victim
	assign fillWay = hitAny ? hitWay : (anyInvalid ? firstInvalid : victim);

	// Word out of the matching line
	assign hitWord = lineRd[hitWay][cmd.addr.word];

	// Round robin victim that only moves when a full set is evicted
	always_ff @(posedge clk) begin
		if (rst) victim <= '0;
		else if (doFill && !hitAny && !anyInvalid) victim <= victim + dcWay'(1);
	end

	// ========================================================================
	// Result register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) resultValid <= 1'b0;
		else resultValid <= cmdValid;
	end

	// A misaligned read is reported as a miss
	// Read data goes out as selected and the output side clears it on a miss
	always_ff @(posedge clk) begin
		if (cmdValid) begin
			result.op <= cmd.op;
			result.err <= cmd.err;
			result.hit <= (doRead && hitAny && !cmd.err) || (doFill && hitAny);
			result.way <= doFill ? fillWay : ((doRead && hitAny && !cmd.err) ? hitWay : '0);
			result.data <= doRead ? hitWord : '0;
		end
	end

endmodule

/* logic/dcacheReqDecode.sv */
// Data cache request decode
`timescale 1ns/100ps

module dcacheReqDecode import dcacheAddrPkg::*, dcacheCmdPkg::*; (
	input logic clk,
	input logic rst,
	// Incoming request, one cycle strobe
	input logic reqValid,
	input dcReq req,
	// Decoded command towards lookup
	output logic cmdValid,
	output dcCmd cmd
);

	// ========================================================================
	// Address split
	// ========================================================================

	// Address fields in cache order
	dcSplitAddr split;

	// Byte offset is nonzero
	logic misaligned;

	// Error flag for the decoded command
	logic cmdErr;

	// A plain cast does the split since the struct mirrors the address
	assign split = dcSplitAddr'(req.addr);

	assign misaligned = |split.byteSel;

	// Only word reads care about alignment
	// Fills and invalidations work on whole lines, so their offset is ignored
	assign cmdErr = (req.op == opRead) && misaligned;

	// ========================================================================
	// Command register
	// ========================================================================

	// Valid strobe one cycle behind the request
	always_ff @(posedge clk) begin
		if (rst) begin
			cmdValid <= 1'b0;
		end else begin
			cmdValid <= reqValid;
		end
	end

	// Payload is captured on every valid request
	always_ff @(posedge clk) begin
		if (reqValid) begin
			cmd.op <= req.op;
			cmd.addr <= split;
			cmd.line <= req.line;
			cmd.err <= cmdErr;
		end
	end

endmodule

/* logic/dcacheWayStore.sv */
// Data cache way store
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcacheWayStore import dcacheAddrPkg::*; #(
	// Payload held per way and set, tag or line
	parameter type entryT = logic
) (
	input logic clk,
	// Single write port
	input logic wr,
	input dcWay wrWay,
	// Set for both the read and the write
	input dcIndex index,
	input entryT wrData,
	// All ways of the indexed set
	output entryT rdData [`DC_WAYS]
);

	// ========================================================================
	// Storage
	// ========================================================================

	// One entry per way and set
	entryT mem [`DC_WAYS][`DC_SETS];

	// Write lands at the clock edge, after this cycle's read has been used
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wrWay][index] <= wrData;
		end
	end

	// Asynchronous read of the whole set
	// Lookup compares every way in the same cycle
	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			rdData[w] = mem[w][index];
		end
	end

endmodule

/* logic/dcacheValid.sv */
// Data cache valid bits
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcacheValid import dcacheAddrPkg::*; (
	input logic clk,
	input logic rst,
	// Line fill sets one bit
	input logic fill,
	input dcWay fillWay,
	// Set addressed by the current command
	input dcIndex index,
	// Invalidation of one set or of the whole cache
	input logic invLine,
	input logic invAll,
	// One bit per set, one vector per way
	output logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid
);

	// ========================================================================
	// Valid array
	// ========================================================================

	// Only one command is active per cycle, but fill still wins over the
	// invalidations so that the priority is well defined
	always_ff @(posedge clk) begin
		if (rst) begin
			// Reset leaves every line empty
			valid <= '0;
		end else if (fill) begin
			// The chosen way of the set now holds a line
			valid[fillWay][index] <= 1'b1;
		end else if (invAll) begin
			// Clear every way and every set at once
			valid <= '0;
		end else if (invLine) begin
			// Clear the addressed set in all ways
			for (int w = 0; w < `DC_WAYS; w++) begin
				valid[w][index] <= 1'b0;
			end
		end
	end

endmodule

/* logic/dcacheCmdPkg.sv */
// Data cache command and response types
`include "dcache_defines.svh"

package dcacheCmdPkg;
	import dcacheAddrPkg::*;

	// Command opcodes
	typedef enum logic [1:0] {
		opRead = 2'd0,
		opFill = 2'd1,
		opInvLine = 2'd2,
		opInvAll = 2'd3
	} dcOp;

	// One cache line, four 32 bit words with word 0 in the low bits
	typedef logic [(1 << (`DC_LOBIT - 2))-1:0][31:0] dcLine;

	// Request as it arrives at the cache boundary
	// The line field only matters for a fill
	typedef struct packed {
		dcOp op;
		logic [`DC_ADDR_W-1:0] addr;
		dcLine line;
	} dcReq;

	// Request after decode, address already split into fields
	typedef struct packed {
		dcOp op;
		dcSplitAddr addr;
		dcLine line;
		logic err;
	} dcCmd;

	// Response for every command
	// For a read, hit and way describe the lookup; for a fill, the way is
	// the one written and hit says an existing tag was reused
	typedef struct packed {
		dcOp op;
		logic hit;
		dcWay way;
		logic [31:0] data;
		logic err;
	} dcResp;

endpackage

/* logic/dcacheAddrPkg.sv */
// Data cache address types
`include "dcache_defines.svh"

package dcacheAddrPkg;

	// Index into the sets
	typedef logic [$clog2(`DC_SETS)-1:0] dcIndex;

	// Everything above the index is tag, 24 bits for this geometry
	typedef logic [`DC_ADDR_W-`DC_LOBIT-$clog2(`DC_SETS)-1:0] dcTag;

	// Word inside a line, the byte offset bits are dropped
	typedef logic [`DC_LOBIT-3:0] dcWordSel;

	// Way number
	typedef logic [$clog2(`DC_WAYS)-1:0] dcWay;

	// An address cut into its cache fields
	// Field order follows the address from the top bit down, so a plain cast
	// of the 32 bit address lands every field in place
	typedef struct packed {
		dcTag tag;
		dcIndex index;
		dcWordSel word;
		logic [1:0] byteSel;
	} dcSplitAddr;

endpackage

/* logic/dcache_defines.svh */
// Data cache geometry
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// ============================================================================
// Cache shape
// ============================================================================

// Number of ways in each set
`define DC_WAYS 4

// Number of sets, which makes the index four bits wide
`define DC_SETS 16

// Lowest index bit of the address
// Everything below it is the offset inside a 16 byte line, so bits 3 and 2
// pick one of the four words and bits 1 and 0 pick the byte
`define DC_LOBIT 4

// ============================================================================
// Address
// ============================================================================

// Width of a request address
`define DC_ADDR_W 32

`endif
